// File: program.hex
// One 32-bit instruction word per line, from RESET_VECTOR upward
00100093
00200113
002081b3
00118213
40110233
0020f2b3
0020e333
0020c3b3
00209433
0020d4b3
00512023
00012503
00a58593
fe5ff06f
00000463
00008067

// File: sim.f
src/rv_fetch_pkg.sv
src/inst_rom.sv
src/inst_cache.sv
src/fetch_unit.sv
src/fetch_top.sv
tests/fetch_props.sv
tests/fetch_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module fetch_tb -f sim.f -o fetch_sim > sim.log 2>&1 &&
    ./obj_dir/fetch_sim >> sim.log 2>&1 ||
    echo "=== FAIL ===" >> sim.log
cat sim.log
if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0

// File: tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import rv_fetch_pkg::*;

    localparam int          PLANNED_EVENTS = 40;
    localparam logic [31:0] TRAP_VECTOR    = RESET_VECTOR + 32'h20;
    localparam logic [31:0] DEBUG_PC       = RESET_VECTOR + 32'h18;

    logic        clk;
    logic        reseted;
    logic [31:0] mtvec;
    logic        irq_timer;
    logic        irq_exti;
    dbg_cmd_t    dbg;
    logic        dbg_mode;
    logic        dbg_done;
    e2f_t        e2f;
    f2e_t        f2e;

    logic [31:0] rom_image [ROM_WORDS];
    logic [31:0] exp_pc;
    logic [31:0] rng;
    logic        took;

    fetch_top dut (
        .clk       (clk),
        .reseted   (reseted),
        .mtvec     (mtvec),
        .irq_timer (irq_timer),
        .irq_exti  (irq_exti),
        .dbg       (dbg),
        .dbg_mode  (dbg_mode),
        .dbg_done  (dbg_done),
        .e2f       (e2f),
        .f2e       (f2e)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ROM word for an aligned pc inside the window
    function automatic logic [31:0] expected_instr(input logic [31:0] pc);
        logic [31:0] offset;
        offset = pc - RESET_VECTOR;
        return rom_image[offset[ROM_INDEX_BITS+1:2]];
    endfunction

    // Interrupts win over a fetch fault
    function automatic logic [31:0] expected_cause(input logic [31:0] pc, input logic ext,
                                                   input logic tmr);
        if (ext) return EXC_EXTERNAL_IRQ;
        if (tmr) return EXC_TIMER_IRQ;
        if (pc[1:0] != 2'b00) return EXC_INSTR_MISALIGNED;
        return EXC_INSTR_ACCESS_FAULT;
    endfunction

    // Next pc once an instruction is taken by execute
    function automatic logic [31:0] next_after_accept(input logic [31:0] pc, input e2f_t e,
                                                      input logic dbg_req);
        if (dbg_req) return pc + 32'd4;
        if (e.exc_return) return e.exc_epc;
        if (e.branchtaken) return e.branchtarget;
        if (e.flush) return pc + 32'd4;
        if (e.exc_start) return mtvec;
        return pc + 32'd4;
    endfunction

    task automatic stop_with_failure();
        $display("=== FAIL ===");
        $fatal(1, "test stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    // Compare delivered words with the reference
    always @(negedge clk) begin
        if (!reseted) begin
            took = 1'b0;
            if (dbg_mode && f2e.instr != INSTR_NOP) begin
                $display("An instruction was delivered while in debug mode at %0t ns", $time);
                stop_with_failure();
            end
            if (f2e.instr != INSTR_NOP && e2f.ready) begin
                took = 1'b1;
                check_value("f2e.pc", f2e.pc, exp_pc);
                check_value("f2e.instr", f2e.instr, expected_instr(exp_pc));
                exp_pc = next_after_accept(f2e.pc, e2f, dbg.request);
            end
            if (f2e.exc_start) begin
                if (!took) begin
                    check_value("f2e.pc", f2e.pc, exp_pc);
                end
                check_value("f2e.cause", f2e.cause, expected_cause(f2e.pc, irq_exti, irq_timer));
                exp_pc = mtvec;
            end
            if (dbg_done) begin
                exp_pc = dbg.pc;
            end
        end
    end

    task automatic wait_accept();
        @(negedge clk);
        while (!(f2e.instr != INSTR_NOP && e2f.ready)) @(negedge clk);
    endtask

    // Ends on the edge after an accepted word that leaves two more words in the window
    task automatic wait_safe();
        do begin
            wait_accept();
        end while (f2e.exc_start || f2e.pc < RESET_VECTOR ||
                   f2e.pc > RESET_VECTOR + ROM_BYTES - 32'd12);
        @(posedge clk);
    endtask

    task automatic wait_exc();
        @(negedge clk);
        while (!f2e.exc_start) @(negedge clk);
    endtask

    task automatic take_branch(input logic [31:0] target);
        wait_safe();
        e2f.branchtaken  <= 1'b1;
        e2f.branchtarget <= target;
        wait_accept();
        @(posedge clk);
        e2f.branchtaken  <= 1'b0;
    endtask

    task automatic raise_irq(input logic ext);
        wait_safe();
        irq_timer <= 1'b1;
        irq_exti  <= ext;
        wait_exc();
        @(posedge clk);
        irq_timer <= 1'b0;
        irq_exti  <= 1'b0;
    endtask

    initial begin
        repeat (PLANNED_EVENTS * 50) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", PLANNED_EVENTS * 50);
        stop_with_failure();
    end

    initial begin
        $readmemh("program.hex", rom_image);
        exp_pc      = RESET_VECTOR;
        rng         = 32'd63978;
        reseted   <= 1'b1;
        mtvec     <= TRAP_VECTOR;
        irq_timer <= 1'b0;
        irq_exti  <= 1'b0;
        dbg       <= '0;
        e2f       <= '0;
        repeat (4) @(posedge clk);
        reseted   <= 1'b0;
        e2f.ready <= 1'b1;

        wait_accept();
        check_value("first f2e.pc", f2e.pc, RESET_VECTOR);

        // Execute stalls at random
        repeat (300) begin
            @(posedge clk);
            rng = xorshift(rng);
            e2f.ready <= rng[1:0] != 2'b00;
        end
        @(posedge clk);
        e2f.ready <= 1'b1;

        repeat (6) begin
            rng = xorshift(rng);
            take_branch(RESET_VECTOR + {26'd0, rng[3:0], 2'b00});
        end

        wait_safe();
        e2f.exc_return <= 1'b1;
        e2f.exc_epc    <= RESET_VECTOR + 32'h8;
        wait_accept();
        @(posedge clk);
        e2f.exc_return <= 1'b0;

        wait_safe();
        e2f.flush <= 1'b1;
        wait_accept();
        @(posedge clk);
        e2f.flush <= 1'b0;
        repeat (4) wait_accept();

        raise_irq(1'b0);
        wait_accept();
        raise_irq(1'b1);
        wait_accept();

        take_branch(RESET_VECTOR + 32'h6);
        wait_exc();
        wait_accept();
        take_branch(32'h0000_4000);
        wait_exc();
        wait_accept();

        wait_safe();
        dbg.request <= 1'b1;
        @(negedge clk);
        while (!dbg_mode) @(negedge clk);
        @(posedge clk);
        dbg.request <= 1'b0;
        dbg.set_pc  <= 1'b1;
        dbg.pc      <= DEBUG_PC;
        @(negedge clk);
        check_value("dbg_done", {31'd0, dbg_done}, 32'd1);
        @(posedge clk);
        dbg.set_pc       <= 1'b0;
        dbg.exit_request <= 1'b1;
        // First word after the halt, a hit may arrive right as dbg_mode drops
        wait_accept();
        check_value("f2e.pc after debug", f2e.pc, DEBUG_PC);
        @(posedge clk);
        dbg.exit_request <= 1'b0;
        repeat (3) wait_accept();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: tests/fetch_props.sv
`timescale 1ns/1ps

module fetch_props (
    input logic                     clk,
    input logic                     reseted,
    input logic                     dbg_mode,
    input rv_fetch_pkg::cache_req_t c_req,
    input rv_fetch_pkg::cache_rsp_t c_rsp,
    input rv_fetch_pkg::f2e_t       f2e
);
    import rv_fetch_pkg::*;

    cause_set: assert property (@(posedge clk) disable iff (reseted)
        f2e.exc_start |-> f2e.cause != '0)
        else $error("exc_start raised with a zero cause");

    // Request held steady while the cache is busy
    request_stable: assert property (@(posedge clk) disable iff (reseted)
        (c_rsp.response == WAIT) |-> $stable(c_req))
        else $error("cache request changed during WAIT");

    halted_nop: assert property (@(posedge clk) disable iff (reseted)
        dbg_mode |-> f2e.instr == INSTR_NOP)
        else $error("instruction presented in debug mode");

endmodule

bind fetch_unit fetch_props u_props (
    .clk      (clk),
    .reseted  (reseted),
    .dbg_mode (dbg_mode),
    .c_req    (c_req),
    .c_rsp    (c_rsp),
    .f2e      (f2e)
);

// File: src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                   clk,
    input  logic                   reseted,
    input  logic [31:0]            mtvec,
    input  logic                   irq_timer,
    input  logic                   irq_exti,
    input  rv_fetch_pkg::dbg_cmd_t dbg,
    output logic                   dbg_mode,
    output logic                   dbg_done,
    input  rv_fetch_pkg::e2f_t     e2f,
    output rv_fetch_pkg::f2e_t     f2e
);
    import rv_fetch_pkg::*;

    // Fetch to cache link
    cache_req_t c_req;
    cache_rsp_t c_rsp;

    // Cache refill port
    rom_req_t   rom_req;
    rom_rsp_t   rom_rsp;

    fetch_unit u_fetch (
        .clk       (clk),
        .reseted   (reseted),
        .mtvec     (mtvec),
        .irq_timer (irq_timer),
        .irq_exti  (irq_exti),
        .dbg       (dbg),
        .dbg_mode  (dbg_mode),
        .dbg_done  (dbg_done),
        .c_req     (c_req),
        .c_rsp     (c_rsp),
        .e2f       (e2f),
        .f2e       (f2e)
    );

    inst_cache u_cache (
        .clk     (clk),
        .reseted (reseted),
        .c_req   (c_req),
        .c_rsp   (c_rsp),
        .rom_req (rom_req),
        .rom_rsp (rom_rsp)
    );

    inst_rom u_rom (
        .clk     (clk),
        .rom_req (rom_req),
        .rom_rsp (rom_rsp)
    );

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                     clk,
    input  logic                     reseted,
    input  logic [31:0]              mtvec,
    input  logic                     irq_timer,
    input  logic                     irq_exti,
    input  rv_fetch_pkg::dbg_cmd_t   dbg,
    output logic                     dbg_mode,
    output logic                     dbg_done,
    output rv_fetch_pkg::cache_req_t c_req,
    input  rv_fetch_pkg::cache_rsp_t c_rsp,
    input  rv_fetch_pkg::e2f_t       e2f,
    output rv_fetch_pkg::f2e_t       f2e
);
    import rv_fetch_pkg::*;

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] saved_instr;
    logic        start_pending;
    logic        flushing;
    logic        after_flush;

    logic        cache_done;
    logic        cache_idle;
    logic        cache_wait;
    logic        cache_error;
    logic        access_end;
    logic [31:0] fault_cause;

    cache_cmd_t  cmd;
    logic [31:0] instr;
    logic        exc_start;
    logic [31:0] cause;

    // Decisions taken this cycle, applied at the clock edge
    logic        advance;
    logic        start_flush;
    logic        enter_dbg;
    logic        leave_dbg;
    logic        flush_end;

    assign cache_done  = c_rsp.response == DONE;
    assign cache_idle  = c_rsp.response == IDLE;
    assign cache_wait  = c_rsp.response == WAIT;
    assign cache_error = (c_rsp.response == ACCESSFAULT) ||
                         (c_rsp.response == MISALIGNED) ||
                         (c_rsp.response == PAGEFAULT);

    // The current access has ended and the next one may be chosen
    assign access_end = start_pending || cache_error ||
                        (e2f.ready && (cache_done || cache_idle));

    always_comb begin
        case (c_rsp.response)
            MISALIGNED:  fault_cause = EXC_INSTR_MISALIGNED;
            ACCESSFAULT: fault_cause = EXC_INSTR_ACCESS_FAULT;
            PAGEFAULT:   fault_cause = EXC_INSTR_PAGE_FAULT;
            default:     fault_cause = '0;
        endcase
    end

    // Instruction shown to execute
    always_comb begin
        instr = INSTR_NOP;
        if (c_rsp.reset_done && !dbg_mode && !(start_pending && cache_idle)) begin
            if (cache_done && !flushing) begin
                instr = c_rsp.load_data;
            end else if (cache_idle && !flushing && !after_flush) begin
                // Execute stalled, keep showing the last word
                instr = saved_instr;
            end
        end
    end

    // Next PC and cache command, in priority order
    always_comb begin
        next_pc     = pc;
        cmd         = NONE;
        exc_start   = 1'b0;
        cause       = '0;
        dbg_done    = 1'b0;
        advance     = 1'b0;
        start_flush = 1'b0;
        enter_dbg   = 1'b0;
        leave_dbg   = 1'b0;
        flush_end   = 1'b0;
        if (!c_rsp.reset_done) begin
            // Cache still clearing its lines
        end else if (dbg_mode) begin
            if (dbg.exit_request) begin
                leave_dbg = 1'b1;
                cmd       = EXECUTE;
            end else if (dbg.set_pc) begin
                next_pc  = dbg.pc;
                dbg_done = 1'b1;
            end
        end else if (flushing) begin
            if (cache_done) begin
                flush_end = 1'b1;
            end else begin
                cmd = FLUSH_ALL;
            end
        end else if (cache_wait) begin
            // Repeat the pending request
            cmd = EXECUTE;
        end else if (access_end) begin
            advance = 1'b1;
            cmd     = EXECUTE;
            if (start_pending) begin
                next_pc = RESET_VECTOR;
            end else if (dbg.request) begin
                cmd       = NONE;
                enter_dbg = 1'b1;
                next_pc   = cache_error ? pc : pc + 32'd4;
            end else if (irq_exti || irq_timer) begin
                exc_start = 1'b1;
                cause     = irq_exti ? EXC_EXTERNAL_IRQ : EXC_TIMER_IRQ;
                next_pc   = mtvec;
            end else if (e2f.exc_return) begin
                next_pc = e2f.exc_epc;
            end else if (e2f.branchtaken) begin
                next_pc = e2f.branchtarget;
            end else if (e2f.ready && e2f.flush) begin
                cmd         = FLUSH_ALL;
                start_flush = 1'b1;
            end else if (e2f.ready && e2f.exc_start) begin
                next_pc = mtvec;
            end else if (cache_error) begin
                exc_start = 1'b1;
                cause     = fault_cause;
                next_pc   = mtvec;
            end else begin
                next_pc = pc + 32'd4;
            end
        end
    end

    assign c_req = '{cmd: cmd, address: next_pc};
    assign f2e   = '{instr: instr, pc: pc, exc_start: exc_start, cause: cause};

    always_ff @(posedge clk) begin
        pc          <= next_pc;
        saved_instr <= instr;
    end

    always_ff @(posedge clk) begin
        if (reseted) begin
            start_pending <= 1'b1;
            flushing      <= 1'b0;
            after_flush   <= 1'b0;
            dbg_mode      <= 1'b0;
        end else begin
            if (advance) begin
                start_pending <= 1'b0;
                after_flush   <= 1'b0;
                flushing      <= start_flush;
                dbg_mode      <= enter_dbg;
            end
            if (leave_dbg) begin
                dbg_mode <= 1'b0;
            end
            if (flush_end) begin
                flushing    <= 1'b0;
                after_flush <= 1'b1;
            end
        end
    end

endmodule

// File: src/inst_cache.sv
`timescale 1ns/1ps

module inst_cache (
    input  logic                     clk,
    input  logic                     reseted,
    input  rv_fetch_pkg::cache_req_t c_req,
    output rv_fetch_pkg::cache_rsp_t c_rsp,
    output rv_fetch_pkg::rom_req_t   rom_req,
    input  rv_fetch_pkg::rom_rsp_t   rom_rsp
);
    import rv_fetch_pkg::*;

    typedef enum logic [1:0] {
        CLEAR,
        READY,
        MISS
    } state_t;

    state_t               state;
    logic [LINE_BITS-1:0] clear_line;
    logic                 reset_done;
    cache_resp_t          response;
    logic                 rom_valid;
    logic [31:0]          load_data;
    logic [31:0]          miss_addr;

    // One word per line
    logic                 line_valid [CACHE_LINES];
    logic [TAG_BITS-1:0]  line_tag   [CACHE_LINES];
    logic [31:0]          line_data  [CACHE_LINES];

    logic [LINE_BITS-1:0] req_line;
    logic [TAG_BITS-1:0]  req_tag;
    logic [LINE_BITS-1:0] miss_line;
    logic [31:0]          rom_offset;
    logic                 in_window;
    logic                 hit;
    logic                 clear_last;

    assign req_line   = c_req.address[LINE_BITS+1:2];
    assign req_tag    = c_req.address[31:LINE_BITS+2];
    assign miss_line  = miss_addr[LINE_BITS+1:2];
    assign rom_offset = miss_addr - RESET_VECTOR;
    assign in_window  = (c_req.address >= RESET_VECTOR) &&
                        (c_req.address < RESET_VECTOR + ROM_BYTES);
    assign hit        = line_valid[req_line] && (line_tag[req_line] == req_tag);
    assign clear_last = clear_line == LINE_BITS'(CACHE_LINES - 1);

    assign rom_req = '{valid: rom_valid, index: rom_offset[ROM_INDEX_BITS+1:2]};
    assign c_rsp   = '{response: response, reset_done: reset_done, load_data: load_data};

    always_ff @(posedge clk) begin
        if (reseted) begin
            state      <= CLEAR;
            clear_line <= '0;
            reset_done <= 1'b0;
            response   <= IDLE;
            rom_valid  <= 1'b0;
        end else begin
            rom_valid <= 1'b0;
            case (state)
                CLEAR: begin
                    clear_line <= clear_line + 1'b1;
                    // Walk after reset answers nothing, a flush walk answers WAIT
                    response   <= reset_done ? WAIT : IDLE;
                    if (clear_last) begin
                        state      <= READY;
                        reset_done <= 1'b1;
                        response   <= reset_done ? DONE : IDLE;
                    end
                end
                READY: begin
                    response <= IDLE;
                    if (c_req.cmd == FLUSH_ALL) begin
                        state      <= CLEAR;
                        clear_line <= '0;
                        response   <= WAIT;
                    end else if (c_req.cmd == EXECUTE) begin
                        if (c_req.address[1:0] != 2'b00) begin
                            response <= MISALIGNED;
                        end else if (!in_window) begin
                            response <= ACCESSFAULT;
                        end else if (hit) begin
                            response <= DONE;
                        end else begin
                            response  <= WAIT;
                            state     <= MISS;
                            rom_valid <= 1'b1;
                        end
                    end
                end
                MISS: begin
                    // Requests repeated by fetch are ignored until the refill lands
                    if (rom_rsp.valid) begin
                        state    <= READY;
                        response <= DONE;
                    end else begin
                        response <= WAIT;
                    end
                end
                default: begin
                    state <= READY;
                end
            endcase
        end
    end

    // Line storage and read data
    always_ff @(posedge clk) begin
        if (state == CLEAR) begin
            line_valid[clear_line] <= 1'b0;
        end
        if (state == READY && c_req.cmd == EXECUTE) begin
            load_data <= line_data[req_line];
            miss_addr <= c_req.address;
        end
        if (state == MISS && rom_rsp.valid) begin
            line_valid[miss_line] <= 1'b1;
            line_tag[miss_line]   <= miss_addr[31:LINE_BITS+2];
            line_data[miss_line]  <= rom_rsp.data;
            load_data             <= rom_rsp.data;
        end
    end

endmodule

// File: src/inst_rom.sv
`timescale 1ns/1ps

module inst_rom (
    input  logic                   clk,
    input  rv_fetch_pkg::rom_req_t rom_req,
    output rv_fetch_pkg::rom_rsp_t rom_rsp
);
    import rv_fetch_pkg::*;

    // Program image, one 32-bit word per line of the hex file
    logic [31:0] mem [ROM_WORDS];

    // Read pipeline, one stage per cycle of latency
    rom_rsp_t    pipe [ROM_LATENCY];

    initial begin
        $readmemh("program.hex", mem);
    end

    always_ff @(posedge clk) begin
        pipe[0] <= '{valid: rom_req.valid, data: mem[rom_req.index]};
        for (int i = 1; i < ROM_LATENCY; i++) begin
            pipe[i] <= pipe[i-1];
        end
    end

    // Several reads may be in flight at once
    assign rom_rsp = pipe[ROM_LATENCY-1];

endmodule

// File: src/rv_fetch_pkg.sv
package rv_fetch_pkg;

    // Commands from fetch to the instruction cache
    typedef enum logic [1:0] {
        NONE      = 2'd0,
        EXECUTE   = 2'd1,
        FLUSH_ALL = 2'd2
    } cache_cmd_t;

    // Cache answers, always for the command of the previous cycle
    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        WAIT        = 3'd1,
        DONE        = 3'd2,
        ACCESSFAULT = 3'd3,
        MISALIGNED  = 3'd4,
        PAGEFAULT   = 3'd5
    } cache_resp_t;

    // Cause codes handed to execute
    localparam logic [31:0] EXC_INSTR_MISALIGNED   = 32'h0000_0010;
    localparam logic [31:0] EXC_INSTR_ACCESS_FAULT = 32'h0000_0001;
    localparam logic [31:0] EXC_INSTR_PAGE_FAULT   = 32'h0000_000C;
    localparam logic [31:0] EXC_TIMER_IRQ          = 32'h8000_0007;
    localparam logic [31:0] EXC_EXTERNAL_IRQ       = 32'h8000_000B;

    // addi x0, x0, 0
    localparam logic [31:0] INSTR_NOP = {12'h0, 5'h0, 3'b000, 5'h0, 7'b0010011};

    localparam logic [31:0] RESET_VECTOR = 32'h0000_2000;

    // ROM window and cache geometry
    localparam int          ROM_WORDS      = 16;
    localparam logic [31:0] ROM_BYTES      = 32'(ROM_WORDS * 4);
    localparam int          ROM_INDEX_BITS = $clog2(ROM_WORDS);
    localparam int          ROM_LATENCY    = 2;
    localparam int          CACHE_LINES    = 8;
    localparam int          LINE_BITS      = $clog2(CACHE_LINES);
    localparam int          TAG_BITS       = 32 - 2 - LINE_BITS;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        exc_start;
        logic [31:0] cause;
    } f2e_t;

    typedef struct packed {
        logic        ready;
        logic        exc_start;
        logic        exc_return;
        logic [31:0] exc_epc;
        logic        flush;
        logic        branchtaken;
        logic [31:0] branchtarget;
    } e2f_t;

    typedef struct packed {
        logic        request;
        logic        set_pc;
        logic        exit_request;
        logic [31:0] pc;
    } dbg_cmd_t;

    typedef struct packed {
        cache_cmd_t  cmd;
        logic [31:0] address;
    } cache_req_t;

    typedef struct packed {
        cache_resp_t response;
        logic        reset_done;
        logic [31:0] load_data;
    } cache_rsp_t;

    typedef struct packed {
        logic                      valid;
        logic [ROM_INDEX_BITS-1:0] index;
    } rom_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } rom_rsp_t;

endpackage
